/* hdl/machine_mode_types_pkg.sv */
//----------------------------------------------------------------------
// machine mode CSR layouts, addresses and trap encodings
// only M mode exists, mstatus.mpp always reads as M
// no dependencies, compile this package first
//----------------------------------------------------------------------

package machine_mode_types_pkg;

  localparam logic [1:0] PRV_M = 2'b11;

  // RV32 (mxl = 1) with only the I extension
  localparam logic [31:0] MISA_VALUE = 32'h4000_0100;

  // information registers, read-only space
  localparam logic [11:0] MVENDORID = 12'hF11;
  localparam logic [11:0] MARCHID   = 12'hF12;
  localparam logic [11:0] MIMPID    = 12'hF13;
  localparam logic [11:0] MHARTID   = 12'hF14;

  // trap setup
  localparam logic [11:0] MSTATUS   = 12'h300;
  localparam logic [11:0] MISA      = 12'h301;
  localparam logic [11:0] MIE       = 12'h304;
  localparam logic [11:0] MTVEC     = 12'h305;

  // trap handling
  localparam logic [11:0] MSCRATCH  = 12'h340;
  localparam logic [11:0] MEPC      = 12'h341;
  localparam logic [11:0] MCAUSE    = 12'h342;
  localparam logic [11:0] MTVAL     = 12'h343;
  localparam logic [11:0] MIP       = 12'h344;

  // timer, non-standard locations
  localparam logic [11:0] MTIMECMP  = 12'h321;
  localparam logic [11:0] MTIME     = 12'h701;
  localparam logic [11:0] MTIMEH    = 12'h741;

  // counters
  localparam logic [11:0] MCYCLE    = 12'hB00;
  localparam logic [11:0] MINSTRET  = 12'hB02;
  localparam logic [11:0] MCYCLEH   = 12'hB80;
  localparam logic [11:0] MINSTRETH = 12'hB82;

  // interrupt cause codes, also the mip/mie bit positions
  localparam logic [30:0] IRQ_SOFT  = 31'd3;
  localparam logic [30:0] IRQ_TIMER = 31'd7;
  localparam logic [30:0] IRQ_EXT   = 31'd11;

  typedef enum logic [3:0] {
    EXC_INSTR_MISALIGN = 4'd0,
    EXC_ILLEGAL_INSTR  = 4'd2,
    EXC_BREAKPOINT     = 4'd3,
    EXC_LOAD_MISALIGN  = 4'd4,
    EXC_STORE_MISALIGN = 4'd6,
    EXC_ECALL_M        = 4'd11
  } exc_cause_t;

  typedef struct packed {
    logic [18:0] zero_0;
    logic [1:0]  mpp;     // fixed at M
    logic [2:0]  zero_1;
    logic        mpie;
    logic [2:0]  zero_2;
    logic        mie;
    logic [2:0]  zero_3;
  } mstatus_t;

  // enable and pending share one layout
  typedef struct packed {
    logic [19:0] zero_0;
    logic        meie;
    logic [2:0]  zero_1;
    logic        mtie;
    logic [2:0]  zero_2;
    logic        msie;
    logic [2:0]  zero_3;
  } mie_t;

  typedef mie_t mip_t;

  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;    // 0 direct, 1 vectored
  } mtvec_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] code;
  } mcause_t;

  // state the trap controller needs every cycle
  typedef struct packed {
    mstatus_t    mstatus;
    mie_t        mie;
    mip_t        mip;
    mtvec_t      mtvec;
    logic [31:0] mepc;
  } csr_state_t;

  typedef struct packed {
    logic        take;    // trap entry
    logic        ret;     // mret
    mcause_t     cause;
    logic [31:0] epc;
    logic [31:0] tval;
  } trap_update_t;

endpackage

/* hdl/rv32i_types_pkg.sv */
//----------------------------------------------------------------------
// base RV32 pipeline types shared by the privilege unit
// compile after machine_mode_types_pkg, exc_req_t carries its cause
// a csr request op other than NONE is a one-cycle strobe
//----------------------------------------------------------------------

package rv32i_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [1:0] {
    NONE = 2'b00,
    SWAP = 2'b01,
    SET  = 2'b10,
    CLR  = 2'b11
  } csr_op_t;

  typedef struct packed {
    csr_addr_t addr;
    csr_op_t   op;   // NONE means idle
    word_t     wdata;
  } csr_req_t;

  typedef struct packed {
    word_t rdata;    // value before this cycle's write
    logic  invalid;
  } csr_resp_t;

  // synchronous exception from the pipeline, single-cycle strobe
  typedef struct packed {
    logic                               valid;
    machine_mode_types_pkg::exc_cause_t cause;
    word_t                              epc;
    word_t                              tval;
  } exc_req_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

endpackage

/* hdl/priv_csr_rfile.sv */
//----------------------------------------------------------------------
// machine CSR storage, 64-bit counters and mtime
// writes land at the next edge, reads show the current value
// SET/CLR with zero wdata is a pure read, mcycle/minstret ignore writes
// trap updates override pipeline writes to mstatus/mepc/mcause/mtval
//----------------------------------------------------------------------
`timescale 1ns/1ns

module priv_csr_rfile (
  input  logic                                 CLK,
  input  logic                                 nRST,
  input  rv32i_types_pkg::csr_req_t            csr_req,
  input  logic                                 instr_retired,
  input  logic                                 ext_irq,
  input  logic                                 sw_irq,
  input  machine_mode_types_pkg::trap_update_t trap_upd,
  output rv32i_types_pkg::csr_resp_t           csr_resp,
  output machine_mode_types_pkg::csr_state_t   csr_state
);

  machine_mode_types_pkg::mstatus_t mstatus;
  machine_mode_types_pkg::mie_t     mie;
  machine_mode_types_pkg::mip_t     mip;
  machine_mode_types_pkg::mtvec_t   mtvec;
  machine_mode_types_pkg::mcause_t  mcause;

  logic status_mie;   // only live mstatus bits
  logic status_mpie;

  rv32i_types_pkg::word_t mscratch;
  rv32i_types_pkg::word_t mepc;
  rv32i_types_pkg::word_t mtval;
  rv32i_types_pkg::word_t mtimecmp;

  logic [63:0] mtime;
  logic [63:0] mtime_inc;
  logic [63:0] mcycle;
  logic [63:0] minstret;

  rv32i_types_pkg::word_t rdata;
  rv32i_types_pkg::word_t wval;
  logic known;
  logic op_active;
  logic is_write;
  logic we;

  always_comb begin
    mstatus      = '0;
    mstatus.mpp  = machine_mode_types_pkg::PRV_M;
    mstatus.mpie = status_mpie;
    mstatus.mie  = status_mie;
  end

  // pending bits are live levels, not stored
  always_comb begin
    mip      = '0;
    mip.meie = ext_irq;
    mip.msie = sw_irq;
    mip.mtie = (mtime[31:0] >= mtimecmp);  // unsigned compare
  end

  // read mux and address decode
  always_comb begin
    rdata = '0;
    known = 1'b1;
    case (csr_req.addr)
      machine_mode_types_pkg::MVENDORID,
      machine_mode_types_pkg::MARCHID,
      machine_mode_types_pkg::MIMPID,
      machine_mode_types_pkg::MHARTID:   rdata = '0;
      machine_mode_types_pkg::MISA:      rdata = machine_mode_types_pkg::MISA_VALUE;
      machine_mode_types_pkg::MSTATUS:   rdata = mstatus;
      machine_mode_types_pkg::MIE:       rdata = mie;
      machine_mode_types_pkg::MTVEC:     rdata = mtvec;
      machine_mode_types_pkg::MSCRATCH:  rdata = mscratch;
      machine_mode_types_pkg::MEPC:      rdata = mepc;
      machine_mode_types_pkg::MCAUSE:    rdata = mcause;
      machine_mode_types_pkg::MTVAL:     rdata = mtval;
      machine_mode_types_pkg::MIP:       rdata = mip;
      machine_mode_types_pkg::MTIMECMP:  rdata = mtimecmp;
      machine_mode_types_pkg::MTIME:     rdata = mtime[31:0];
      machine_mode_types_pkg::MTIMEH:    rdata = mtime[63:32];
      machine_mode_types_pkg::MCYCLE:    rdata = mcycle[31:0];
      machine_mode_types_pkg::MCYCLEH:   rdata = mcycle[63:32];
      machine_mode_types_pkg::MINSTRET:  rdata = minstret[31:0];
      machine_mode_types_pkg::MINSTRETH: rdata = minstret[63:32];
      default:                           known = 1'b0;
    endcase
  end

  assign op_active = (csr_req.op != rv32i_types_pkg::NONE);
  assign is_write  = (csr_req.op == rv32i_types_pkg::SWAP) || (|csr_req.wdata);

  assign csr_resp.rdata   = rdata;
  assign csr_resp.invalid = op_active &
                            (~known | (is_write & (csr_req.addr[11:10] == 2'b11)));

  assign we = op_active & is_write & ~csr_resp.invalid;

  // read-modify-write value
  always_comb begin
    case (csr_req.op)
      rv32i_types_pkg::SWAP: wval = csr_req.wdata;
      rv32i_types_pkg::SET:  wval = rdata | csr_req.wdata;
      rv32i_types_pkg::CLR:  wval = rdata & ~csr_req.wdata;
      default:               wval = rdata;
    endcase
  end

  // trap state, the trap update has priority
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      status_mie  <= 1'b0;
      status_mpie <= 1'b0;
      mepc        <= '0;
      mcause      <= '0;
      mtval       <= '0;
    end else if (trap_upd.take) begin
      status_mpie <= status_mie;
      status_mie  <= 1'b0;
      mepc        <= trap_upd.epc;
      mcause      <= trap_upd.cause;
      mtval       <= trap_upd.tval;
    end else begin
      if (trap_upd.ret) begin
        status_mie  <= status_mpie;
        status_mpie <= 1'b1;
      end else if (we && csr_req.addr == machine_mode_types_pkg::MSTATUS) begin
        status_mie  <= wval[3];
        status_mpie <= wval[7];
      end
      // mret leaves these alone
      if (we && csr_req.addr == machine_mode_types_pkg::MEPC)
        mepc <= wval;
      if (we && csr_req.addr == machine_mode_types_pkg::MCAUSE)
        mcause <= wval;
      if (we && csr_req.addr == machine_mode_types_pkg::MTVAL)
        mtval <= wval;
    end
  end

  // pipeline-only registers
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mtimecmp <= '0;
    end else if (we) begin
      case (csr_req.addr)
        machine_mode_types_pkg::MIE: begin
          mie.meie <= wval[11];
          mie.mtie <= wval[7];
          mie.msie <= wval[3];
        end
        machine_mode_types_pkg::MTVEC: begin
          mtvec.base <= wval[31:2];
          mtvec.mode <= (wval[1:0] == 2'b01) ? 2'b01 : 2'b00;  // reserved modes -> direct
        end
        machine_mode_types_pkg::MSCRATCH: mscratch <= wval;
        machine_mode_types_pkg::MTIMECMP: mtimecmp <= wval;
        default: ;  // mip, misa, counters ignore writes
      endcase
    end
  end

  assign mtime_inc = mtime + 64'd1;

  // counters run every cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mtime    <= '0;
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      mcycle <= mcycle + 64'd1;
      if (instr_retired)
        minstret <= minstret + 64'd1;
      if (we && csr_req.addr == machine_mode_types_pkg::MTIME)
        mtime <= {mtime_inc[63:32], wval};
      else if (we && csr_req.addr == machine_mode_types_pkg::MTIMEH)
        mtime <= {wval, mtime_inc[31:0]};  // other half keeps counting
      else
        mtime <= mtime_inc;
    end
  end

  assign csr_state.mstatus = mstatus;
  assign csr_state.mie     = mie;
  assign csr_state.mip     = mip;
  assign csr_state.mtvec   = mtvec;
  assign csr_state.mepc    = mepc;

endmodule

/* hdl/priv_trap_ctrl.sv */
//----------------------------------------------------------------------
// trap decision, purely combinational
// priority: exception, then enabled interrupt, then mret
// interrupts rank external, software, timer
// vectored mode only offsets interrupt targets
//----------------------------------------------------------------------
`timescale 1ns/1ns

module priv_trap_ctrl (
  input  machine_mode_types_pkg::csr_state_t   csr_state,
  input  rv32i_types_pkg::exc_req_t            exc,
  input  logic                                 mret,
  input  rv32i_types_pkg::word_t               irq_pc,
  output machine_mode_types_pkg::trap_update_t trap_upd,
  output rv32i_types_pkg::redirect_t           redirect
);

  machine_mode_types_pkg::mie_t pending;
  logic                         irq_take;
  logic [30:0]                  irq_code;
  rv32i_types_pkg::word_t       tvec_base;
  rv32i_types_pkg::word_t       tvec_irq;

  // pending and enabled
  always_comb begin
    pending      = '0;
    pending.meie = csr_state.mip.meie & csr_state.mie.meie;
    pending.msie = csr_state.mip.msie & csr_state.mie.msie;
    pending.mtie = csr_state.mip.mtie & csr_state.mie.mtie;
  end

  assign irq_take = csr_state.mstatus.mie & (pending.meie | pending.msie | pending.mtie);

  always_comb begin
    if (pending.meie)
      irq_code = machine_mode_types_pkg::IRQ_EXT;
    else if (pending.msie)
      irq_code = machine_mode_types_pkg::IRQ_SOFT;
    else
      irq_code = machine_mode_types_pkg::IRQ_TIMER;
  end

  assign tvec_base = {csr_state.mtvec.base, 2'b00};
  assign tvec_irq  = (csr_state.mtvec.mode == 2'b01) ?
                     tvec_base + {irq_code[29:0], 2'b00} :  // base + 4*code
                     tvec_base;

  always_comb begin
    trap_upd = '0;
    redirect = '0;
    if (exc.valid) begin
      trap_upd.take            = 1'b1;
      trap_upd.cause.interrupt = 1'b0;
      trap_upd.cause.code      = {27'd0, exc.cause};
      trap_upd.epc             = exc.epc;
      trap_upd.tval            = exc.tval;
      redirect.target          = tvec_base;
    end else if (irq_take) begin
      trap_upd.take            = 1'b1;
      trap_upd.cause.interrupt = 1'b1;
      trap_upd.cause.code      = irq_code;
      trap_upd.epc             = irq_pc;  // tval stays zero
      redirect.target          = tvec_irq;
    end else if (mret) begin
      trap_upd.ret             = 1'b1;
      redirect.target          = csr_state.mepc;
    end
    redirect.valid = trap_upd.take | trap_upd.ret;
  end

endmodule

/* hdl/priv_unit.sv */
//----------------------------------------------------------------------
// machine mode privilege unit top
// redirect is combinational from its cause, no back-pressure
// interrupt inputs are levels, all other requests one-cycle strobes
//----------------------------------------------------------------------
`timescale 1ns/1ns

module priv_unit (
  input  logic                       CLK,
  input  logic                       nRST,
  input  rv32i_types_pkg::csr_req_t  csr_req,
  input  rv32i_types_pkg::exc_req_t  exc,
  input  logic                       mret,
  input  rv32i_types_pkg::word_t     irq_pc,
  input  logic                       instr_retired,
  input  logic                       ext_irq,
  input  logic                       sw_irq,
  output rv32i_types_pkg::csr_resp_t csr_resp,
  output rv32i_types_pkg::redirect_t redirect
);

  machine_mode_types_pkg::csr_state_t   csr_state;
  machine_mode_types_pkg::trap_update_t trap_upd;

  priv_csr_rfile priv_csr_rfile_inst (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_req       (csr_req),
    .instr_retired (instr_retired),
    .ext_irq       (ext_irq),
    .sw_irq        (sw_irq),
    .trap_upd      (trap_upd),
    .csr_resp      (csr_resp),
    .csr_state     (csr_state)
  );

  priv_trap_ctrl priv_trap_ctrl_inst (
    .csr_state (csr_state),
    .exc       (exc),
    .mret      (mret),
    .irq_pc    (irq_pc),
    .trap_upd  (trap_upd),
    .redirect  (redirect)
  );

endmodule

/* sim/priv_unit_properties.sv */
//----------------------------------------------------------------------
// concurrent checks bound into priv_unit
// csr_state comes from the bound scope for the interrupt condition
// fail_count rises on every assertion failure
//----------------------------------------------------------------------
`timescale 1ns/1ns

module priv_unit_properties (
  input logic                               CLK,
  input logic                               nRST,
  input rv32i_types_pkg::csr_req_t          csr_req,
  input rv32i_types_pkg::exc_req_t          exc,
  input logic                               mret,
  input rv32i_types_pkg::csr_resp_t         csr_resp,
  input rv32i_types_pkg::redirect_t         redirect,
  input machine_mode_types_pkg::csr_state_t csr_state
);

  int unsigned fail_count = 0;
  logic        irq_ready;   // enabled, pending and globally on

  assign irq_ready = csr_state.mstatus.mie & (|(csr_state.mip & csr_state.mie));

  redirect_has_cause: assert property (@(posedge CLK) disable iff (!nRST)
    redirect.valid |-> exc.valid || mret || irq_ready)
    else begin
      $error("redirect raised without exception, mret or enabled interrupt");
      fail_count++;
    end

  invalid_needs_op: assert property (@(posedge CLK) disable iff (!nRST)
    csr_resp.invalid |-> csr_req.op != rv32i_types_pkg::NONE)
    else begin
      $error("invalid raised with no CSR request");
      fail_count++;
    end

  // first cycle out of reset with nothing requested
  quiet_after_reset: assert property (@(posedge CLK)
    $rose(nRST) && csr_req.op == rv32i_types_pkg::NONE && !exc.valid && !mret
    |-> !redirect.valid && !csr_resp.invalid)
    else begin
      $error("redirect or invalid high in the first cycle after reset");
      fail_count++;
    end

endmodule

/* sim/priv_unit_tb.sv */
//----------------------------------------------------------------------
// self-checking testbench for priv_unit against a cycle model
// inputs change after the rising edge, outputs checked at the falling edge
// stops at the first mismatch, assertion failures are counted at the end
//----------------------------------------------------------------------
`timescale 1ns/1ns

module priv_unit_tb;

  logic                       CLK;
  logic                       nRST;
  rv32i_types_pkg::csr_req_t  csr_req;
  rv32i_types_pkg::exc_req_t  exc;
  logic                       mret;
  rv32i_types_pkg::word_t     irq_pc;
  logic                       instr_retired;
  logic                       ext_irq;
  logic                       sw_irq;
  rv32i_types_pkg::csr_resp_t csr_resp;
  rv32i_types_pkg::redirect_t redirect;

  // model of the machine state
  logic                       m_sie;    // mstatus.mie
  logic                       m_spie;   // mstatus.mpie
  rv32i_types_pkg::word_t     m_mie;
  rv32i_types_pkg::word_t     m_mtvec;
  rv32i_types_pkg::word_t     m_mscratch;
  rv32i_types_pkg::word_t     m_mepc;
  rv32i_types_pkg::word_t     m_mcause;
  rv32i_types_pkg::word_t     m_mtval;
  rv32i_types_pkg::word_t     m_mtimecmp;
  logic [63:0]                m_mtime;
  logic [63:0]                m_mcycle;
  logic [63:0]                m_minstret;
  logic                       seen_redirect;
  rv32i_types_pkg::csr_addr_t addr;
  int                         i;
  int                         waited;

  priv_unit priv_unit_inst (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_req       (csr_req),
    .exc           (exc),
    .mret          (mret),
    .irq_pc        (irq_pc),
    .instr_retired (instr_retired),
    .ext_irq       (ext_irq),
    .sw_irq        (sw_irq),
    .csr_resp      (csr_resp),
    .redirect      (redirect)
  );

  bind priv_unit priv_unit_properties priv_unit_props_inst (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic rv32i_types_pkg::csr_addr_t rw_addr(input int unsigned n);
    case (n % 5)
      0:       return machine_mode_types_pkg::MSCRATCH;
      1:       return machine_mode_types_pkg::MTVEC;
      2:       return machine_mode_types_pkg::MIE;
      3:       return machine_mode_types_pkg::MEPC;
      default: return machine_mode_types_pkg::MTIMECMP;
    endcase
  endfunction

  function automatic rv32i_types_pkg::csr_addr_t counter_addr(input int unsigned n);
    case (n % 6)
      0:       return machine_mode_types_pkg::MCYCLE;
      1:       return machine_mode_types_pkg::MCYCLEH;
      2:       return machine_mode_types_pkg::MINSTRET;
      3:       return machine_mode_types_pkg::MINSTRETH;
      4:       return machine_mode_types_pkg::MTIME;
      default: return machine_mode_types_pkg::MTIMEH;
    endcase
  endfunction

  function automatic machine_mode_types_pkg::exc_cause_t exc_pick(input int unsigned n);
    case (n % 6)
      0:       return machine_mode_types_pkg::EXC_INSTR_MISALIGN;
      1:       return machine_mode_types_pkg::EXC_ILLEGAL_INSTR;
      2:       return machine_mode_types_pkg::EXC_BREAKPOINT;
      3:       return machine_mode_types_pkg::EXC_LOAD_MISALIGN;
      4:       return machine_mode_types_pkg::EXC_STORE_MISALIGN;
      default: return machine_mode_types_pkg::EXC_ECALL_M;
    endcase
  endfunction

  function automatic rv32i_types_pkg::word_t model_mip();
    rv32i_types_pkg::word_t p;
    p     = '0;
    p[11] = ext_irq;
    p[7]  = (m_mtime[31:0] >= m_mtimecmp);  // unsigned
    p[3]  = sw_irq;
    return p;
  endfunction

  // external, then software, then timer
  function automatic int irq_code(input rv32i_types_pkg::word_t pend);
    if (pend[11])
      return 11;
    if (pend[3])
      return 3;
    return 7;
  endfunction

  function automatic rv32i_types_pkg::word_t model_read(input rv32i_types_pkg::csr_addr_t a,
                                                        output logic known);
    known = 1'b1;
    case (a)
      machine_mode_types_pkg::MVENDORID, machine_mode_types_pkg::MARCHID,
      machine_mode_types_pkg::MIMPID, machine_mode_types_pkg::MHARTID: return '0;
      machine_mode_types_pkg::MISA:      return machine_mode_types_pkg::MISA_VALUE;
      machine_mode_types_pkg::MSTATUS:   return 32'h1800 | (m_spie << 7) | (m_sie << 3);
      machine_mode_types_pkg::MIE:       return m_mie;
      machine_mode_types_pkg::MTVEC:     return m_mtvec;
      machine_mode_types_pkg::MSCRATCH:  return m_mscratch;
      machine_mode_types_pkg::MEPC:      return m_mepc;
      machine_mode_types_pkg::MCAUSE:    return m_mcause;
      machine_mode_types_pkg::MTVAL:     return m_mtval;
      machine_mode_types_pkg::MIP:       return model_mip();
      machine_mode_types_pkg::MTIMECMP:  return m_mtimecmp;
      machine_mode_types_pkg::MTIME:     return m_mtime[31:0];
      machine_mode_types_pkg::MTIMEH:    return m_mtime[63:32];
      machine_mode_types_pkg::MCYCLE:    return m_mcycle[31:0];
      machine_mode_types_pkg::MCYCLEH:   return m_mcycle[63:32];
      machine_mode_types_pkg::MINSTRET:  return m_minstret[31:0];
      machine_mode_types_pkg::MINSTRETH: return m_minstret[63:32];
      default: begin
        known = 1'b0;
        return '0;
      end
    endcase
  endfunction

  function automatic rv32i_types_pkg::csr_resp_t predict_resp();
    rv32i_types_pkg::csr_resp_t r;
    logic                       known;
    logic                       wr;
    r.rdata   = model_read(csr_req.addr, known);
    wr        = (csr_req.op == rv32i_types_pkg::SWAP) || (csr_req.wdata != '0);
    r.invalid = (csr_req.op != rv32i_types_pkg::NONE) &&
                (!known || (wr && csr_req.addr[11:10] == 2'b11));
    return r;
  endfunction

  function automatic rv32i_types_pkg::redirect_t predict_redirect();
    rv32i_types_pkg::redirect_t r;
    rv32i_types_pkg::word_t     pend;
    rv32i_types_pkg::word_t     base;
    pend = model_mip() & m_mie;
    base = {m_mtvec[31:2], 2'b00};
    r    = '0;
    if (exc.valid) begin
      r.valid  = 1'b1;
      r.target = base;
    end else if (m_sie && pend != '0) begin
      r.valid  = 1'b1;
      r.target = (m_mtvec[1:0] == 2'b01) ? base + 4 * irq_code(pend) : base;
    end else if (mret) begin
      r.valid  = 1'b1;
      r.target = m_mepc;
    end
    return r;
  endfunction

  // advance the model by one edge with the inputs of this cycle
  task automatic model_step();
    rv32i_types_pkg::csr_resp_t resp;
    rv32i_types_pkg::word_t     wval;
    rv32i_types_pkg::word_t     pend;
    logic                       irq;
    logic                       we;
    logic                       old_sie;
    logic                       old_spie;
    logic [63:0]                next_time;
    resp     = predict_resp();
    pend     = model_mip() & m_mie;
    irq      = m_sie && pend != '0;
    old_sie  = m_sie;
    old_spie = m_spie;
    we = (csr_req.op != rv32i_types_pkg::NONE) && !resp.invalid &&
         (csr_req.op == rv32i_types_pkg::SWAP || csr_req.wdata != '0);
    case (csr_req.op)
      rv32i_types_pkg::SWAP: wval = csr_req.wdata;
      rv32i_types_pkg::SET:  wval = resp.rdata | csr_req.wdata;
      default:               wval = resp.rdata & ~csr_req.wdata;
    endcase
    next_time = m_mtime + 64'd1;
    if (we && csr_req.addr == machine_mode_types_pkg::MTIME)
      next_time[31:0] = wval;
    if (we && csr_req.addr == machine_mode_types_pkg::MTIMEH)
      next_time[63:32] = wval;
    m_mtime  = next_time;
    m_mcycle = m_mcycle + 64'd1;
    if (instr_retired)
      m_minstret = m_minstret + 64'd1;
    if (we) begin
      case (csr_req.addr)
        machine_mode_types_pkg::MIE:      m_mie = wval & 32'h0000_0888;
        machine_mode_types_pkg::MTVEC:    m_mtvec = {wval[31:2], 1'b0, wval[1:0] == 2'b01};
        machine_mode_types_pkg::MSCRATCH: m_mscratch = wval;
        machine_mode_types_pkg::MTIMECMP: m_mtimecmp = wval;
        machine_mode_types_pkg::MEPC:     m_mepc = wval;
        machine_mode_types_pkg::MCAUSE:   m_mcause = wval;
        machine_mode_types_pkg::MTVAL:    m_mtval = wval;
        machine_mode_types_pkg::MSTATUS: begin
          m_sie  = wval[3];
          m_spie = wval[7];
        end
        default: ;
      endcase
    end
    // trap events overwrite any CSR write of the same cycle
    if (exc.valid || irq) begin
      m_spie   = old_sie;
      m_sie    = 1'b0;
      m_mepc   = exc.valid ? exc.epc : irq_pc;
      m_mcause = exc.valid ? {28'd0, exc.cause} : {1'b1, 31'(irq_code(pend))};
      m_mtval  = exc.valid ? exc.tval : '0;
    end else if (mret) begin
      m_sie  = old_spie;
      m_spie = 1'b1;
    end
  endtask

  task automatic fail_stop();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic compare_resp(input rv32i_types_pkg::csr_resp_t got,
                              input rv32i_types_pkg::csr_resp_t exp);
    if (got !== exp) begin
      $display("[ERROR] csr_resp addr=%h rdata=%h invalid=%h, expected rdata=%h invalid=%h",
               csr_req.addr, got.rdata, got.invalid, exp.rdata, exp.invalid);
      fail_stop();
    end
  endtask

  task automatic compare_redirect(input rv32i_types_pkg::redirect_t got,
                                  input rv32i_types_pkg::redirect_t exp);
    if (got !== exp) begin
      $display("[ERROR] redirect valid=%h target=%h, expected valid=%h target=%h",
               got.valid, got.target, exp.valid, exp.target);
      fail_stop();
    end
  endtask

  task automatic run_cycle();
    rv32i_types_pkg::redirect_t exp_redirect;
    @(negedge CLK);
    exp_redirect = predict_redirect();
    compare_resp(csr_resp, predict_resp());
    compare_redirect(redirect, exp_redirect);
    seen_redirect = exp_redirect.valid;
    @(posedge CLK);
    model_step();
  endtask

  task automatic clear_strobes();
    csr_req       <= '0;
    exc           <= '0;
    mret          <= 1'b0;
    irq_pc        <= $urandom;
    instr_retired <= 1'($urandom_range(0, 1));
  endtask

  task automatic csr_access(input rv32i_types_pkg::csr_op_t op,
                            input rv32i_types_pkg::csr_addr_t a,
                            input rv32i_types_pkg::word_t wdata);
    clear_strobes();
    csr_req <= '{addr: a, op: op, wdata: wdata};
    run_cycle();
  endtask

  initial begin
    void'($urandom(32'h9db8334c));
    nRST          = 1'b0;
    csr_req       = '0;
    exc           = '0;
    mret          = 1'b0;
    irq_pc        = '0;
    instr_retired = 1'b0;
    ext_irq       = 1'b0;
    sw_irq        = 1'b0;
    {m_sie, m_spie, m_mie, m_mtvec, m_mscratch, m_mepc} = '0;
    {m_mcause, m_mtval, m_mtimecmp, m_mtime, m_mcycle, m_minstret} = '0;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    clear_strobes();
    run_cycle();

    // read-modify-write on the writable registers, then read back
    for (i = 0; i < 40; i++) begin
      addr = rw_addr($urandom);
      csr_access(rv32i_types_pkg::csr_op_t'($urandom_range(1, 3)), addr, $urandom);
      csr_access(rv32i_types_pkg::SET, addr, '0);
    end

    // info registers, random (mostly unknown) addresses, misa
    for (i = 0; i < 20; i++) begin
      addr = machine_mode_types_pkg::MVENDORID + 12'($urandom_range(0, 3));
      csr_access(rv32i_types_pkg::SWAP, addr, $urandom);
      csr_access(rv32i_types_pkg::csr_op_t'($urandom_range(1, 3)), 12'($urandom), $urandom);
      csr_access(rv32i_types_pkg::SET, machine_mode_types_pkg::MISA, '0);
    end
    for (i = 0; i < 5; i++)
      csr_access(rv32i_types_pkg::SET, rw_addr(i), '0);

    // exceptions, half of them colliding with a CSR write
    csr_access(rv32i_types_pkg::SWAP, machine_mode_types_pkg::MTVEC, $urandom);
    for (i = 0; i < 20; i++) begin
      clear_strobes();
      exc <= '{valid: 1'b1, cause: exc_pick($urandom), epc: $urandom, tval: $urandom};
      if ($urandom_range(0, 1) == 1)
        csr_req <= '{addr: machine_mode_types_pkg::MEPC + 12'($urandom_range(0, 2)),
                     op: rv32i_types_pkg::SWAP, wdata: $urandom};
      run_cycle();
      csr_access(rv32i_types_pkg::SET, machine_mode_types_pkg::MEPC, '0);
      csr_access(rv32i_types_pkg::SET, machine_mode_types_pkg::MCAUSE, '0);
      csr_access(rv32i_types_pkg::SET, machine_mode_types_pkg::MTVAL, '0);
      csr_access(rv32i_types_pkg::SET, machine_mode_types_pkg::MSTATUS, '0);
    end

    // random interrupt levels and enables, vectored mode
    csr_access(rv32i_types_pkg::SWAP, machine_mode_types_pkg::MTVEC,
               ($urandom & 32'hFFFF_FF00) | 32'h1);
    for (i = 0; i < 80; i++) begin
      clear_strobes();
      ext_irq <= 1'($urandom_range(0, 1));
      sw_irq  <= 1'($urandom_range(0, 1));
      case ($urandom_range(0, 5))
        0: csr_req <= '{addr: machine_mode_types_pkg::MIE, op: rv32i_types_pkg::SWAP,
                        wdata: $urandom};
        1: csr_req <= '{addr: machine_mode_types_pkg::MSTATUS, op: rv32i_types_pkg::SWAP,
                        wdata: $urandom};
        2: mret <= 1'b1;
        3: csr_req <= '{addr: machine_mode_types_pkg::MTIMECMP, op: rv32i_types_pkg::SWAP,
                        wdata: m_mtime[31:0] + $urandom_range(0, 8)};
        4: csr_req <= '{addr: machine_mode_types_pkg::MSTATUS, op: rv32i_types_pkg::SET,
                        wdata: '0};
        default: ;
      endcase
      run_cycle();
    end

    // timer compare alone, wait for the interrupt
    ext_irq <= 1'b0;
    sw_irq  <= 1'b0;
    csr_access(rv32i_types_pkg::SWAP, machine_mode_types_pkg::MSTATUS, '0);
    csr_access(rv32i_types_pkg::SWAP, machine_mode_types_pkg::MTIME, '0);
    csr_access(rv32i_types_pkg::SWAP, machine_mode_types_pkg::MIE, 32'h80);
    csr_access(rv32i_types_pkg::SWAP, machine_mode_types_pkg::MTIMECMP, 32'd40);
    csr_access(rv32i_types_pkg::SWAP, machine_mode_types_pkg::MSTATUS, 32'h8);
    waited        = 0;
    seen_redirect = 1'b0;
    while (!seen_redirect) begin
      if (waited == 100) begin
        $display("timeout: timer interrupt never redirected the pipeline");
        fail_stop();
      end
      clear_strobes();
      run_cycle();
      waited++;
    end
    clear_strobes();
    mret <= 1'b1;  // back to mepc with mie restored
    run_cycle();
    csr_access(rv32i_types_pkg::SWAP, machine_mode_types_pkg::MIE, '0);
    csr_access(rv32i_types_pkg::SET, machine_mode_types_pkg::MSTATUS, '0);

    // counters and mtime halves
    for (i = 0; i < 30; i++) begin
      case ($urandom_range(0, 3))
        0: csr_access(rv32i_types_pkg::SWAP, machine_mode_types_pkg::MTIME, $urandom);
        1: csr_access(rv32i_types_pkg::SWAP, machine_mode_types_pkg::MTIMEH, $urandom);
        default: ;
      endcase
      csr_access(rv32i_types_pkg::SET, counter_addr($urandom), '0);
    end

    clear_strobes();
    run_cycle();
    if (priv_unit_inst.priv_unit_props_inst.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      fail_stop();
    end
  end

endmodule

/* list.f */
hdl/machine_mode_types_pkg.sv
hdl/rv32i_types_pkg.sv
hdl/priv_csr_rfile.sv
hdl/priv_trap_ctrl.sv
hdl/priv_unit.sv
sim/priv_unit_properties.sv
sim/priv_unit_tb.sv
